/* hdl/rv32i_types.sv */
package rv32i_types;

    // #########################################################################
    // basic words
    // #########################################################################

    typedef logic [31:0] word_t;
    typedef logic [3:0]  tag_t;    // reorder buffer index.

    localparam int default_station_depth = 4;

    // #########################################################################
    // operation classes and alu codes
    // #########################################################################

    // class set by decode, picks the alu operands.
    typedef enum logic [2:0] {
        ARITH,
        ARITH_IMM,
        AUIPC,
        JAL,
        JALR,
        BRANCH
    } op_t;

    // funct3 order; sub and sra ride on funct7 bit 5.
    typedef enum logic [2:0] {
        alu_add  = 3'b000,
        alu_sll  = 3'b001,
        alu_slt  = 3'b010,
        alu_sltu = 3'b011,
        alu_xor  = 3'b100,
        alu_srl  = 3'b101,
        alu_or   = 3'b110,
        alu_and  = 3'b111
    } alu_ops;

    // #########################################################################
    // payload structs
    // #########################################################################

    // value when valid, else waiting on tag.
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t data;
    } operand_t;

    typedef struct packed {
        op_t        op;
        operand_t   src1;
        operand_t   src2;
        word_t      imm;
        word_t      pc;
        logic [2:0] funct3;
        logic [6:0] funct7;
        tag_t       dest;
    } issue_t;

    // operands already resolved.
    typedef struct packed {
        op_t        op;
        word_t      src1;
        word_t      src2;
        word_t      imm;
        word_t      pc;
        logic [2:0] funct3;
        logic [6:0] funct7;
        tag_t       dest;
    } alu_req_t;

    typedef struct packed {
        tag_t  tag;
        word_t data;
    } cdb_t;

endpackage

/* hdl/alu_station.sv */
`timescale 1ns/1ps

module alu_station #(
    parameter int depth = rv32i_types::default_station_depth
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   issue_valid,
    output logic                   issue_ready,
    input  rv32i_types::issue_t    issue,
    input  logic                   cdb_valid,
    input  rv32i_types::cdb_t      cdb,
    output logic                   disp_valid,
    input  logic                   disp_ready,
    output rv32i_types::alu_req_t  disp
);
    import rv32i_types::*;

    localparam int iw = (depth > 1) ? $clog2(depth) : 1;

    typedef logic [iw-1:0] slot_t;

    issue_t            entry [depth];
    slot_t             age   [depth];    // number of younger busy entries.
    logic [depth-1:0]  busy;
    logic [depth-1:0]  rdy;

    slot_t  free_idx;
    slot_t  search_idx;
    logic   search_found;
    slot_t  sel_idx;
    slot_t  hold_idx;
    logic   hold_valid;
    logic   do_issue;
    logic   do_disp;
    issue_t issue_snooped;

    // capture a pending operand whose tag is on the cdb.
    function automatic operand_t snoop(operand_t o, logic v, cdb_t c);
        operand_t r;
        r = o;
        if (!o.valid && v && (o.tag == c.tag)) begin
            r.valid = 1'b1;
            r.data  = c.data;
        end
        return r;
    endfunction

    assign issue_ready = !(&busy);
    assign do_issue    = issue_valid && issue_ready;
    assign do_disp     = disp_valid && disp_ready;

    always_comb begin
        issue_snooped      = issue;
        issue_snooped.src1 = snoop(issue.src1, cdb_valid, cdb);    // same-cycle wakeup.
        issue_snooped.src2 = snoop(issue.src2, cdb_valid, cdb);
    end

    // #########################################################################
    // slot selection
    // #########################################################################

    always_comb begin
        free_idx = '0;
        for (int i = depth - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_idx = slot_t'(i);
            end
        end
    end

    always_comb begin
        search_found = 1'b0;
        search_idx   = '0;
        for (int i = 0; i < depth; i++) begin
            rdy[i] = busy[i] && entry[i].src1.valid && entry[i].src2.valid;
            if (rdy[i] && (!search_found || age[i] > age[search_idx])) begin
                search_found = 1'b1;
                search_idx   = slot_t'(i);
            end
        end
    end

    // a stalled dispatch keeps its slot, so an older wakeup cannot cut in.
    assign sel_idx    = hold_valid ? hold_idx : search_idx;
    assign disp_valid = hold_valid || search_found;

    always_comb begin
        disp.op     = entry[sel_idx].op;
        disp.src1   = entry[sel_idx].src1.data;
        disp.src2   = entry[sel_idx].src2.data;
        disp.imm    = entry[sel_idx].imm;
        disp.pc     = entry[sel_idx].pc;
        disp.funct3 = entry[sel_idx].funct3;
        disp.funct7 = entry[sel_idx].funct7;
        disp.dest   = entry[sel_idx].dest;
    end

    // #########################################################################
    // state
    // #########################################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= '0;
            hold_valid <= 1'b0;
            hold_idx   <= '0;
            for (int i = 0; i < depth; i++) begin
                age[i] <= '0;
            end
        end else begin
            hold_valid <= disp_valid && !disp_ready;
            hold_idx   <= sel_idx;
            for (int i = 0; i < depth; i++) begin
                if (do_disp && (sel_idx == slot_t'(i))) begin
                    busy[i] <= 1'b0;
                end else if (busy[i]) begin
                    age[i] <= age[i] + slot_t'(do_issue)
                            - slot_t'(do_disp && (age[i] > age[sel_idx]));
                end
            end
            if (do_issue) begin
                busy[free_idx] <= 1'b1;
                age[free_idx]  <= '0;    // youngest.
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < depth; i++) begin
            if (busy[i]) begin
                entry[i].src1 <= snoop(entry[i].src1, cdb_valid, cdb);
                entry[i].src2 <= snoop(entry[i].src2, cdb_valid, cdb);
            end
        end
        if (do_issue) begin
            entry[free_idx] <= issue_snooped;
        end
    end

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   disp_valid,
    output logic                   disp_ready,
    input  rv32i_types::alu_req_t  disp,
    output logic                   alu_valid,
    input  logic                   alu_ready,
    output rv32i_types::cdb_t      alu_result
);
    import rv32i_types::*;

    word_t  a;
    word_t  b;
    alu_ops aluop;
    logic   alt;       // sub or sra.
    word_t  result;

    // empty, or being drained this cycle.
    assign disp_ready = !alu_valid || alu_ready;

    always_comb begin
        a     = disp.pc;
        b     = disp.imm;
        aluop = alu_add;
        alt   = 1'b0;
        case (disp.op)
            ARITH: begin
                a     = disp.src1;
                b     = disp.src2;
                aluop = alu_ops'(disp.funct3);
                alt   = disp.funct7[5] && (aluop == alu_add || aluop == alu_srl);
            end
            ARITH_IMM: begin
                a     = disp.src1;
                aluop = alu_ops'(disp.funct3);
                alt   = disp.funct7[5] && (aluop == alu_srl);    // no subi.
            end
            JAL, JALR: begin
                b = 32'd4;    // link value.
            end
            default: ;        // auipc, branch take pc + imm.
        endcase
    end

    always_comb begin
        unique case (aluop)
            alu_add:  result = alt ? a - b : a + b;
            alu_sll:  result = a << b[4:0];
            alu_slt:  result = {31'b0, $signed(a) < $signed(b)};
            alu_sltu: result = {31'b0, a < b};
            alu_xor:  result = a ^ b;
            alu_srl:  result = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            alu_or:   result = a | b;
            alu_and:  result = a & b;
        endcase
    end

    // #########################################################################
    // output register
    // #########################################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_valid <= 1'b0;
        end else if (disp_valid && disp_ready) begin
            alu_valid <= 1'b1;
        end else if (alu_ready) begin
            alu_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (disp_valid && disp_ready) begin
            alu_result.tag  <= disp.dest;
            alu_result.data <= result;
        end
    end

endmodule

/* hdl/cdb_arbiter.sv */
`timescale 1ns/1ps

module cdb_arbiter (
    input  logic               clk,
    input  logic               reset,
    input  logic               alu_valid,
    output logic               alu_ready,
    input  rv32i_types::cdb_t  alu_result,
    input  logic               ext_valid,
    output logic               ext_ready,
    input  rv32i_types::cdb_t  ext_result,
    output logic               cdb_valid,
    output rv32i_types::cdb_t  cdb
);
    import rv32i_types::*;

    logic last_ext;    // external port won the last grant.
    logic grant_alu;
    logic grant_ext;

    // #########################################################################
    // grant
    // #########################################################################

    // alternate when both ask.
    always_comb begin
        grant_ext = ext_valid && (!alu_valid || !last_ext);
        grant_alu = alu_valid && !grant_ext;
    end

    // the cdb never stalls, so a grant is a transfer.
    assign alu_ready = grant_alu;
    assign ext_ready = grant_ext;

    always_ff @(posedge clk) begin
        if (reset) begin
            last_ext <= 1'b0;
        end else if (grant_alu || grant_ext) begin
            last_ext <= grant_ext;
        end
    end

    // #########################################################################
    // broadcast register
    // #########################################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= grant_alu || grant_ext;    // one cycle per grant.
        end
    end

    always_ff @(posedge clk) begin
        if (grant_ext) begin
            cdb <= ext_result;
        end else if (grant_alu) begin
            cdb <= alu_result;
        end
    end

endmodule

/* hdl/exec_cluster.sv */
`timescale 1ns/1ps

module exec_cluster #(
    parameter int station_depth = rv32i_types::default_station_depth
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 issue_valid,
    output logic                 issue_ready,
    input  rv32i_types::issue_t  issue,
    input  logic                 ext_valid,
    output logic                 ext_ready,
    input  rv32i_types::cdb_t    ext_result,
    output logic                 cdb_valid,
    output rv32i_types::cdb_t    cdb
);
    import rv32i_types::*;

    logic     disp_valid;
    logic     disp_ready;
    alu_req_t disp;
    logic     alu_valid;
    logic     alu_ready;
    cdb_t     alu_result;

    // station wakes up from the same bus it drives out.
    alu_station #(
        .depth (station_depth)
    ) u_station (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue       (issue),
        .cdb_valid   (cdb_valid),
        .cdb         (cdb),
        .disp_valid  (disp_valid),
        .disp_ready  (disp_ready),
        .disp        (disp)
    );

    alu u_alu (
        .clk        (clk),
        .reset      (reset),
        .disp_valid (disp_valid),
        .disp_ready (disp_ready),
        .disp       (disp),
        .alu_valid  (alu_valid),
        .alu_ready  (alu_ready),
        .alu_result (alu_result)
    );

    cdb_arbiter u_arbiter (
        .clk        (clk),
        .reset      (reset),
        .alu_valid  (alu_valid),
        .alu_ready  (alu_ready),
        .alu_result (alu_result),
        .ext_valid  (ext_valid),
        .ext_ready  (ext_ready),
        .ext_result (ext_result),
        .cdb_valid  (cdb_valid),
        .cdb        (cdb)
    );

endmodule

/* sim/exec_cluster_asserts.sv */
`timescale 1ns/1ps

module exec_cluster_asserts (
    input logic                  clk,
    input logic                  reset,
    input logic                  issue_ready,
    input logic                  disp_valid,
    input logic                  disp_ready,
    input rv32i_types::alu_req_t disp,
    input logic                  alu_valid,
    input logic                  alu_ready,
    input rv32i_types::cdb_t     alu_result,
    input logic                  cdb_valid,
    input rv32i_types::cdb_t     cdb
);

    // a tag goes out once, never on two cycles in a row.
    cdb_one_cycle: assert property (@(posedge clk) disable iff (reset)
        cdb_valid |=> !(cdb_valid && (cdb.tag == $past(cdb.tag))))
        else $error("cdb broadcast of one tag lasted more than one cycle");

    disp_stable: assert property (@(posedge clk) disable iff (reset)
        disp_valid && !disp_ready |=> disp_valid && $stable(disp))
        else $error("disp changed while stalled");

    alu_hold: assert property (@(posedge clk) disable iff (reset)
        alu_valid && !alu_ready |=> alu_valid && $stable(alu_result))
        else $error("alu_result changed while held");

    ready_after_reset: assert property (@(posedge clk)
        $past(reset) && !reset |-> issue_ready)    // station empty.
        else $error("issue_ready low after reset");

endmodule

bind exec_cluster exec_cluster_asserts u_asserts (.*);

/* sim/tb_exec_cluster.sv */
`timescale 1ns/1ps

module tb_exec_cluster;
    import rv32i_types::*;

    localparam logic [1:0] k_issue = 2'd0;
    localparam logic [1:0] k_ext   = 2'd1;
    localparam logic [1:0] k_drain = 2'd2;

    typedef struct packed {
        logic [1:0] kind;
        issue_t     iss;    // ext rows carry tag in dest, data in imm.
    } row_t;

    logic   clk;
    logic   reset;
    logic   issue_valid;
    logic   issue_ready;
    issue_t issue;
    logic   ext_valid;
    logic   ext_ready;
    cdb_t   ext_result;
    logic   cdb_valid;
    cdb_t   cdb;

    row_t   rows[$];
    integer seed = 88060;
    int     errors = 0;
    int     issued = 0;
    int     bcasts = 0;
    int     cycles = 0;
    int     limit = 0;
    logic   saw_full = 1'b0;

    // scoreboard indexed by tag.
    logic   pending  [16];
    logic   is_ext   [16];
    issue_t sb_iss   [16];
    word_t  val1     [16];
    word_t  val2     [16];
    logic   wait1    [16];
    logic   wait2    [16];
    word_t  exp_word;

    exec_cluster #(.station_depth(4)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout: not every issued tag reached the CDB within %0d cycles", limit);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic operand_t ready_op(word_t d);
        return '{valid: 1'b1, tag: 4'd0, data: d};
    endfunction

    function automatic operand_t pending_op(tag_t t);
        return '{valid: 1'b0, tag: t, data: 32'h0};
    endfunction

    // ##########################################################################
    // reference model of the alu rules
    // ##########################################################################

    function automatic word_t alu_model(issue_t r, word_t s1, word_t s2);
        word_t a;
        word_t b;
        logic  alt;
        a   = s1;
        b   = s2;
        alt = 1'b0;
        case (r.op)
            ARITH:     alt = r.funct7[5];
            ARITH_IMM: begin
                b   = r.imm;
                alt = r.funct7[5] && (r.funct3 == 3'd5);
            end
            AUIPC, BRANCH: return r.pc + r.imm;
            default:       return r.pc + 32'd4;    // link value.
        endcase
        case (r.funct3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic add_issue(op_t op, operand_t s1, operand_t s2, word_t imm, word_t pc,
                             logic [2:0] f3, logic [6:0] f7, tag_t dest);
        rows.push_back('{kind: k_issue, iss: '{op: op, src1: s1, src2: s2, imm: imm, pc: pc,
                                               funct3: f3, funct7: f7, dest: dest}});
    endtask

    task automatic add_ext(tag_t t, word_t d);
        rows.push_back('{kind: k_ext, iss: '{op: ARITH, src1: '0, src2: '0, imm: d, pc: '0,
                                             funct3: '0, funct7: '0, dest: t}});
    endtask

    task automatic add_drain();
        rows.push_back('{kind: k_drain, iss: '0});
    endtask

    task automatic record(logic ext, issue_t x);
        pending[x.dest] = 1'b1;
        is_ext[x.dest]  = ext;
        sb_iss[x.dest]  = x;
        val1[x.dest]    = x.src1.data;
        val2[x.dest]    = x.src2.data;
        wait1[x.dest]   = !ext && !x.src1.valid;
        wait2[x.dest]   = !ext && !x.src2.valid;
        issued++;
    endtask

    function automatic int open_tags();
        int n;
        n = 0;
        for (int i = 0; i < 16; i++) begin
            n += int'(pending[i]);
        end
        return n;
    endfunction

    // every task starts and ends 2 ns after a rising edge.
    task automatic apply_row(row_t r);
        if (r.kind == k_drain) begin
            while (open_tags() != 0) begin
                @(posedge clk);
                #2;
            end
        end else begin
            while (pending[r.iss.dest]) begin    // tag must be retired before reuse.
                @(posedge clk);
                #2;
            end
            if (r.kind == k_ext) begin
                repeat ({$random(seed)} % 3) begin
                    @(posedge clk);
                    #2;
                end
                record(1'b1, r.iss);
                ext_result = '{tag: r.iss.dest, data: r.iss.imm};
                ext_valid  = 1'b1;
                do @(negedge clk); while (!ext_ready);
                @(posedge clk);
                #2;
                ext_valid = 1'b0;
            end else begin
                record(1'b0, r.iss);
                issue       = r.iss;
                issue_valid = 1'b1;
                do @(negedge clk); while (!issue_ready);
                @(posedge clk);
                #2;
                issue_valid = 1'b0;
            end
        end
    endtask

    // ##########################################################################
    // cdb monitor
    // ##########################################################################

    always @(negedge clk) begin
        if (!reset) begin
            if (!issue_ready) saw_full = 1'b1;
            if (cdb_valid) begin
                bcasts++;
                if (!pending[cdb.tag]) begin
                    $display("ERROR t=%0t: tag %0d broadcast without a pending issue",
                             $time, cdb.tag);
                    errors++;
                end else begin
                    if (wait1[cdb.tag] || wait2[cdb.tag]) begin
                        $display("ERROR t=%0t: tag %0d broadcast before its operand arrived",
                                 $time, cdb.tag);
                        errors++;
                    end
                    exp_word = is_ext[cdb.tag] ? sb_iss[cdb.tag].imm
                             : alu_model(sb_iss[cdb.tag], val1[cdb.tag], val2[cdb.tag]);
                    if (cdb.data !== exp_word) begin
                        $display("ERROR t=%0t: tag %0d carried %h, expected %h",
                                 $time, cdb.tag, cdb.data, exp_word);
                        errors++;
                    end
                    pending[cdb.tag] = 1'b0;
                    for (int u = 0; u < 16; u++) begin    // wake waiting model entries.
                        if (pending[u] && wait1[u] && sb_iss[u].src1.tag == cdb.tag) begin
                            val1[u]  = exp_word;
                            wait1[u] = 1'b0;
                        end
                        if (pending[u] && wait2[u] && sb_iss[u].src2.tag == cdb.tag) begin
                            val2[u]  = exp_word;
                            wait2[u] = 1'b0;
                        end
                    end
                end
            end
        end
    end

    initial begin
        reset       = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        ext_valid   = 1'b0;
        ext_result  = '0;
        for (int i = 0; i < 16; i++) begin
            pending[i] = 1'b0;
            wait1[i]   = 1'b0;
            wait2[i]   = 1'b0;
        end
        // op, src1, src2, imm, pc, funct3, funct7, dest.
        add_issue(ARITH, ready_op(32'h10), ready_op(32'h20), 0, 0, 3'd0, 7'h00, 4'd1);
        add_issue(ARITH, ready_op(32'd5), ready_op(32'd9), 0, 0, 3'd0, 7'h20, 4'd2);
        add_issue(ARITH, ready_op(32'd1), ready_op(32'd35), 0, 0, 3'd1, 7'h00, 4'd3);
        add_issue(ARITH, ready_op(32'hffffffff), ready_op(32'd1), 0, 0, 3'd2, 7'h00, 4'd4);
        add_issue(ARITH, ready_op(32'hffffffff), ready_op(32'd1), 0, 0, 3'd3, 7'h00, 4'd5);
        add_issue(ARITH, ready_op(32'hf0f0), ready_op(32'h00ff), 0, 0, 3'd4, 7'h00, 4'd6);
        add_issue(ARITH, ready_op(32'h80000000), ready_op(32'd4), 0, 0, 3'd5, 7'h00, 4'd7);
        add_issue(ARITH, ready_op(32'h80000000), ready_op(32'd4), 0, 0, 3'd5, 7'h20, 4'd8);
        add_issue(ARITH, ready_op(32'h0f00), ready_op(32'h00f0), 0, 0, 3'd6, 7'h00, 4'd9);
        add_issue(ARITH, ready_op(32'hff00), ready_op(32'h0ff0), 0, 0, 3'd7, 7'h00, 4'd10);
        add_issue(ARITH_IMM, ready_op(32'h100), ready_op(0), 32'd1, 0, 3'd0, 7'h20, 4'd11);
        add_issue(ARITH_IMM, ready_op(32'hfffffffe), ready_op(0), 32'hffffffff, 0, 3'd2,
                  7'h7f, 4'd12);
        add_issue(ARITH_IMM, ready_op(32'd1), ready_op(0), 32'hffffffff, 0, 3'd3, 7'h7f,
                  4'd13);
        add_issue(ARITH_IMM, ready_op(32'hf0000000), ready_op(0), 32'd8, 0, 3'd5, 7'h20,
                  4'd14);
        add_issue(AUIPC, ready_op(0), ready_op(0), 32'h2000, 32'h1000, 3'd0, 7'h00, 4'd15);
        add_issue(BRANCH, ready_op(0), ready_op(0), 32'hfffffff0, 32'h2000, 3'd0, 7'h00, 4'd0);
        add_issue(JAL, ready_op(0), ready_op(0), 32'h100, 32'h3000, 3'd0, 7'h00, 4'd1);
        add_issue(JALR, ready_op(32'h40), ready_op(0), 32'h8, 32'h4000, 3'd0, 7'h00, 4'd2);
        add_drain();
        // fill the station with entries waiting on one external tag.
        add_issue(ARITH, pending_op(4'd9), ready_op(32'd1), 0, 0, 3'd0, 7'h00, 4'd3);
        add_issue(ARITH_IMM, pending_op(4'd9), ready_op(0), 32'hff, 0, 3'd4, 7'h00, 4'd4);
        add_issue(ARITH, ready_op(32'h100), pending_op(4'd9), 0, 0, 3'd0, 7'h20, 4'd5);
        add_issue(ARITH, pending_op(4'd9), pending_op(4'd9), 0, 0, 3'd3, 7'h00, 4'd6);
        add_ext(4'd9, 32'h12345678);
        add_drain();
        add_ext(4'd10, 32'h00000007);
        add_issue(ARITH, pending_op(4'd10), ready_op(32'd2), 0, 0, 3'd1, 7'h00, 4'd7);
        add_issue(ARITH, pending_op(4'd7), ready_op(32'd3), 0, 0, 3'd0, 7'h00, 4'd8);
        add_issue(ARITH_IMM, pending_op(4'd8), ready_op(0), 32'hffffffff, 0, 3'd4, 7'h00,
                  4'd9);
        add_ext(4'd11, 32'hcafef00d);
        add_issue(ARITH, ready_op(32'hffff0000), ready_op(32'h12345678), 0, 0, 3'd7, 7'h00,
                  4'd12);
        add_ext(4'd13, 32'h0badbeef);
        add_issue(ARITH_IMM, ready_op(32'd3), ready_op(0), 32'd4, 0, 3'd1, 7'h00, 4'd14);
        add_ext(4'd15, 32'h5555aaaa);
        limit = rows.size() * 40;

        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        apply_row('{kind: k_drain, iss: '0});
        repeat (5) @(posedge clk);

        if (!saw_full) begin
            $display("issue_ready never fell while the station was full");
            errors++;
        end
        if (issued != bcasts) begin
            $display("%0d tags were issued but %0d broadcasts were seen", issued, bcasts);
            errors++;
        end
        $display("errors: %0d, issued: %0d, broadcasts: %0d", errors, issued, bcasts);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* build.f */
hdl/rv32i_types.sv
hdl/alu_station.sv
hdl/alu.sv
hdl/cdb_arbiter.sv
hdl/exec_cluster.sv
sim/exec_cluster_asserts.sv
sim/tb_exec_cluster.sv

/* Makefile */
# Verilator flow for the execution cluster testbench.

VERILATOR ?= verilator
TOP       ?= tb_exec_cluster
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
EXTRA     ?=

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BIN) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "Regression passed" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
